//--- Bender.yml
package:
  name: reservation_station

sources:
  - rs_pkg.sv
  - rs_entry.sv
  - rs_alloc.sv
  - rs_issue_select.sv
  - reservation_station.sv
  - target: test
    files:
      - rs_checker.sv
      - rs_tb.sv

//--- project.f
rs_pkg.sv
rs_entry.sv
rs_alloc.sv
rs_issue_select.sv
reservation_station.sv
rs_checker.sv
rs_tb.sv

//--- reservation_station.sv
// Top level of the eight-entry reservation station, between rename, the CDBs and the units
`timescale 1ns/1ps
`default_nettype none

module reservation_station
(
	input  wire logic                      clock,
	input  wire logic                      reset,
	input  wire logic                      dispatch_valid,  // Rename offers an instruction
	input  rs_pkg::dispatch_t              dispatch,
	input  rs_pkg::cdb_t                   cdb1,
	input  rs_pkg::cdb_t                   cdb2,
	input  wire logic [rs_pkg::NUM_FU-1:0] fu_available,    // Indexed by fu_sel_e
	output logic                           dispatch_ready,  // Station not full
	output rs_pkg::issue_t                 issue_alu,
	output rs_pkg::issue_t                 issue_mult,
	output rs_pkg::issue_t                 issue_mem
);

	import rs_pkg::*;

	////////////////////////////////////////
	// Entry-level wiring
	////////////////////////////////////////

	logic [NUM_ENTRIES-1:0] busy;               // Occupied slots
	logic [NUM_ENTRIES-1:0] load;               // One-hot write strobe
	logic [NUM_ENTRIES-1:0] request;            // Ready to issue
	logic [NUM_ENTRIES-1:0] issue_grant;        // Leaving this cycle
	fu_sel_e                entry_fu [NUM_ENTRIES];
	issue_t                 entry_contents [NUM_ENTRIES];

	rs_alloc u_alloc
	(
		.busy           (busy),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.load           (load)
	);

	// Dispatch and CDBs fan out to every slot
	for (genvar i = 0; i < NUM_ENTRIES; i++)
	begin : g_entry
		rs_entry u_entry
		(
			.clock       (clock),
			.reset       (reset),
			.load        (load[i]),
			.dispatch    (dispatch),
			.cdb1        (cdb1),
			.cdb2        (cdb2),
			.issue_grant (issue_grant[i]),
			.request     (request[i]),
			.fu          (entry_fu[i]),
			.busy        (busy[i]),
			.contents    (entry_contents[i])
		);
	end

	rs_issue_select u_select
	(
		.request      (request),
		.fu           (entry_fu),
		.contents     (entry_contents),
		.fu_available (fu_available),
		.issue_grant  (issue_grant),
		.issue_alu    (issue_alu),
		.issue_mult   (issue_mult),
		.issue_mem    (issue_mem)
	);

endmodule

`default_nettype wire

//--- rs_alloc.sv
// Free-slot allocator for the reservation station, steers each accepted dispatch to one entry
`timescale 1ns/1ps
`default_nettype none

module rs_alloc
(
	input  wire logic [rs_pkg::NUM_ENTRIES-1:0] busy,           // Occupied slots
	input  wire logic                           dispatch_valid, // Rename has an instruction
	output logic                                dispatch_ready, // Some slot is free
	output logic      [rs_pkg::NUM_ENTRIES-1:0] load            // One-hot write strobe
);

	import rs_pkg::*;

	logic [NUM_ENTRIES-1:0] free;               // Inverse of busy
	logic [NUM_ENTRIES-1:0] first_free;         // Lowest free slot, one-hot
	logic                   found;              // Scan already hit a slot

	////////////////////////////////////////
	// Priority encode
	////////////////////////////////////////

	assign free = ~busy;

	// Walk upward and keep only the first free slot
	always_comb
	begin
		first_free = '0;
		found      = 1'b0;
		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			if (free[i] && !found)
			begin
				first_free[i] = 1'b1;
				found         = 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////

	assign dispatch_ready = |free;              // Not full

	// Write only on an actual transfer
	always_comb
	begin
		if (dispatch_valid && dispatch_ready)
		begin
			load = first_free;
		end
		else
		begin
			load = '0;
		end
	end

endmodule

`default_nettype wire

//--- rs_checker.sv
// Protocol assertions for the reservation station, bound into every reservation_station instance
`timescale 1ns/1ps
`default_nettype none

module rs_checker
(
	input  wire logic                           clock,
	input  wire logic                           reset,
	input  wire logic [rs_pkg::NUM_FU-1:0]      fu_available,
	input  rs_pkg::issue_t                      issue_alu,
	input  rs_pkg::issue_t                      issue_mult,
	input  rs_pkg::issue_t                      issue_mem,
	input  wire logic [rs_pkg::NUM_ENTRIES-1:0] issue_grant,    // Internal grant vector
	input  wire logic [rs_pkg::NUM_ENTRIES-1:0] load,           // Internal write strobe
	input  wire logic [rs_pkg::NUM_ENTRIES-1:0] busy            // Internal occupancy
);

	import rs_pkg::*;

	////////////////////////////////////////
	// Issue side
	////////////////////////////////////////

	a_alu_avail: assert property (@(posedge clock) disable iff (reset)
		issue_alu.valid |-> fu_available[FU_ALU])
		else $error("ALU packet valid while ALU unavailable");

	a_mult_avail: assert property (@(posedge clock) disable iff (reset)
		issue_mult.valid |-> fu_available[FU_MULT])
		else $error("Multiplier packet valid while multiplier unavailable");

	a_mem_avail: assert property (@(posedge clock) disable iff (reset)
		issue_mem.valid |-> fu_available[FU_MEM])
		else $error("Memory packet valid while memory unit unavailable");

	// Shared entry would merge two grants into one bit
	a_grant_unique: assert property (@(posedge clock) disable iff (reset)
		$countones(issue_grant) == $countones({issue_alu.valid, issue_mult.valid, issue_mem.valid}))
		else $error("Grant count differs from valid issue packets");

	////////////////////////////////////////
	// Dispatch side
	////////////////////////////////////////

	a_no_load_full: assert property (@(posedge clock) disable iff (reset)
		(&busy) |-> (load == '0))
		else $error("Entry loaded while station full");

endmodule

bind reservation_station rs_checker u_checker
(
	.clock        (clock),
	.reset        (reset),
	.fu_available (fu_available),
	.issue_alu    (issue_alu),
	.issue_mult   (issue_mult),
	.issue_mem    (issue_mem),
	.issue_grant  (issue_grant),
	.load         (load),
	.busy         (busy)
);

`default_nettype wire

//--- rs_entry.sv
// Single reservation station slot, instantiated once per entry by the station top level
`timescale 1ns/1ps
`default_nettype none

module rs_entry
(
	input  wire logic          clock,
	input  wire logic          reset,
	input  wire logic          load,                // Write strobe from allocator
	input  rs_pkg::dispatch_t  dispatch,            // Instruction from rename
	input  rs_pkg::cdb_t       cdb1,                // First result bus
	input  rs_pkg::cdb_t       cdb2,                // Second result bus
	input  wire logic          issue_grant,         // Selected for issue this cycle
	output logic               request,             // Both operands ready
	output rs_pkg::fu_sel_e    fu,                  // Target unit
	output logic               busy,                // Slot occupied
	output rs_pkg::issue_t     contents             // Payload for the issue mux
);

	import rs_pkg::*;

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	logic             in_use;                       // Slot holds a live instruction
	operand_t         opa;                          // Operand A, value or pending tag
	operand_t         opb;                          // Operand B, value or pending tag
	logic [TAG_W-1:0] dest_tag;
	logic [ROB_W-1:0] rob_idx;
	op_type_e         op;
	fu_sel_e          fu_reg;                       // Latched target unit

	operand_t         opa_src;                      // Operand before wakeup
	operand_t         opb_src;
	operand_t         opa_next;                     // Operand after wakeup
	operand_t         opb_next;

	// Fill a pending operand from whichever bus carries its tag
	function automatic operand_t wake(operand_t cur, cdb_t c1, cdb_t c2);
		operand_t res;
		res = cur;
		if (!cur.valid && c1.valid && (c1.tag == cur.data[TAG_W-1:0]))
		begin
			res.valid = 1'b1;
			res.data  = c1.data;
		end
		if (!cur.valid && c2.valid && (c2.tag == cur.data[TAG_W-1:0]))
		begin
			res.valid = 1'b1;
			res.data  = c2.data;
		end
		return res;
	endfunction

	////////////////////////////////////////
	// Wakeup
	////////////////////////////////////////

	// Loading slot snoops the buses on the incoming operands
	always_comb
	begin
		opa_src = load ? dispatch.opa : opa;    // Bypass on dispatch cycle
		opb_src = load ? dispatch.opb : opb;
	end

	assign opa_next = wake(opa_src, cdb1, cdb2);
	assign opb_next = wake(opb_src, cdb1, cdb2);

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			in_use <= 1'b0;                     // All slots free
		end
		else if (load)
		begin
			in_use <= 1'b1;
		end
		else if (issue_grant)
		begin
			in_use <= 1'b0;                     // Freed as it leaves
		end
	end

	// Payload and operands, written on load or while waiting
	always_ff @(posedge clock)
	begin
		if (load)
		begin
			opa      <= opa_next;
			opb      <= opb_next;
			dest_tag <= dispatch.dest_tag;
			rob_idx  <= dispatch.rob_idx;
			op       <= dispatch.op;
			fu_reg   <= dispatch.fu;
		end
		else if (in_use)
		begin
			opa <= opa_next;                    // Capture late results
			opb <= opb_next;
		end
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	assign busy    = in_use;
	assign request = in_use && opa.valid && opb.valid;
	assign fu      = fu_reg;

	// Valid bit is owned by the selector
	assign contents = '{
		valid:    1'b0,
		opa:      opa.data,
		opb:      opb.data,
		dest_tag: dest_tag,
		rob_idx:  rob_idx,
		op:       op
	};

endmodule

`default_nettype wire

//--- rs_issue_select.sv
// Issue arbiter for the reservation station, one grant and one packet per functional unit
`timescale 1ns/1ps
`default_nettype none

module rs_issue_select
(
	input  wire logic [rs_pkg::NUM_ENTRIES-1:0] request,        // Entry ready to go
	input  rs_pkg::fu_sel_e                     fu [rs_pkg::NUM_ENTRIES],
	input  rs_pkg::issue_t                      contents [rs_pkg::NUM_ENTRIES],
	input  wire logic [rs_pkg::NUM_FU-1:0]      fu_available,   // Unit can accept
	output logic      [rs_pkg::NUM_ENTRIES-1:0] issue_grant,    // Entries leaving now
	output rs_pkg::issue_t                      issue_alu,
	output rs_pkg::issue_t                      issue_mult,
	output rs_pkg::issue_t                      issue_mem
);

	import rs_pkg::*;

	logic [NUM_ENTRIES-1:0] req_by_fu [NUM_FU]; // Requests split per unit
	logic [NUM_FU-1:0]      hit;                // Unit has a candidate
	logic [NUM_FU-1:0]      granted;            // Candidate and unit free
	logic [ENTRY_W-1:0]     sel_idx [NUM_FU];   // Lowest candidate index
	issue_t                 pkt [NUM_FU];       // Outgoing packets

	////////////////////////////////////////
	// Candidate masks
	////////////////////////////////////////

	always_comb
	begin
		for (int u = 0; u < NUM_FU; u++)
		begin
			for (int i = 0; i < NUM_ENTRIES; i++)
			begin
				req_by_fu[u][i] = request[i] && (fu[i] == fu_sel_e'(u));
			end
		end
	end

	////////////////////////////////////////
	// Lowest-entry pick
	////////////////////////////////////////

	// Scan downward so the lowest index is the last write
	always_comb
	begin
		for (int u = 0; u < NUM_FU; u++)
		begin
			hit[u]     = 1'b0;
			sel_idx[u] = '0;
			for (int i = NUM_ENTRIES - 1; i >= 0; i--)
			begin
				if (req_by_fu[u][i])
				begin
					hit[u]     = 1'b1;
					sel_idx[u] = ENTRY_W'(i);
				end
			end
		end
	end

	assign granted = hit & fu_available;        // Held back while unit is busy

	////////////////////////////////////////
	// Grants and packets
	////////////////////////////////////////

	// Units never share an entry since each entry targets one unit
	always_comb
	begin
		issue_grant = '0;
		for (int u = 0; u < NUM_FU; u++)
		begin
			pkt[u] = '0;                        // Idle unit sees zeros
			if (granted[u])
			begin
				issue_grant[sel_idx[u]] = 1'b1;
				pkt[u]                  = contents[sel_idx[u]];
				pkt[u].valid            = 1'b1;
			end
		end
	end

	assign issue_alu  = pkt[FU_ALU];
	assign issue_mult = pkt[FU_MULT];
	assign issue_mem  = pkt[FU_MEM];

endmodule

`default_nettype wire

//--- rs_pkg.sv
// Shared sizes, opcode and unit enums, and bus structs for the reservation station and its testbench
`default_nettype none

package rs_pkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////

	localparam int NUM_ENTRIES = 8;                     // Station depth
	localparam int XLEN        = 64;                    // Operand width
	localparam int PRN_SIZE    = 64;                    // Physical registers
	localparam int TAG_W       = $clog2(PRN_SIZE);      // Physical tag width
	localparam int ROB_SIZE    = 32;                    // ROB depth
	localparam int ROB_W       = $clog2(ROB_SIZE);      // ROB index width
	localparam int ENTRY_W     = $clog2(NUM_ENTRIES);   // Entry index width
	localparam int NUM_FU      = 3;                     // ALU, multiplier, memory

	////////////////////////////////////////
	// Enums
	////////////////////////////////////////

	// Target unit, doubles as the index into fu_available
	typedef enum logic [1:0]
	{
		FU_ALU  = 2'd0,                                 // Adder / logic
		FU_MULT = 2'd1,                                 // Multiplier
		FU_MEM  = 2'd2                                  // Load / store
	} fu_sel_e;

	typedef enum logic [5:0]
	{
		OP_ADD  = 6'h00,
		OP_SUB  = 6'h01,
		OP_AND  = 6'h02,
		OP_OR   = 6'h03,
		OP_XOR  = 6'h04,
		OP_MUL  = 6'h10,                                // Low half of product
		OP_MULH = 6'h11,                                // High half of product
		OP_LD   = 6'h20,
		OP_ST   = 6'h21
	} op_type_e;

	////////////////////////////////////////
	// Structs
	////////////////////////////////////////

	// Low TAG_W bits of data carry the awaited tag while valid is clear
	typedef struct packed
	{
		logic            valid;                         // Value present
		logic [XLEN-1:0] data;                          // Value or tag
	} operand_t;

	typedef struct packed
	{
		logic             valid;                        // Broadcast this cycle
		logic [TAG_W-1:0] tag;                          // Producing register
		logic [XLEN-1:0]  data;                         // Result value
	} cdb_t;

	typedef struct packed
	{
		operand_t         opa;
		operand_t         opb;
		logic [TAG_W-1:0] dest_tag;                     // Result register
		logic [ROB_W-1:0] rob_idx;                      // ROB slot
		op_type_e         op;
		fu_sel_e          fu;                           // Target unit
	} dispatch_t;

	typedef struct packed
	{
		logic             valid;                        // Unit takes it this cycle
		logic [XLEN-1:0]  opa;
		logic [XLEN-1:0]  opb;
		logic [TAG_W-1:0] dest_tag;
		logic [ROB_W-1:0] rob_idx;
		op_type_e         op;
	} issue_t;

endpackage

`default_nettype wire

//--- rs_tb.sv
// Directed testbench for the reservation station, run as the simulation top with the checker bound in
`timescale 1ns/1ps
`default_nettype none

module rs_tb;

	import rs_pkg::*;

	localparam int  CLK_PERIOD    = 4;                  // ns
	localparam int  SEED          = 57916;
	localparam int  READY_WAIT    = 20;                 // Cycles a dispatch may stall
	localparam int  RANDOM_CYCLES = 200;
	localparam int  TEST_OPS      = 60 + RANDOM_CYCLES; // Rough count of test operations
	localparam int  OP_BOUND_NS   = 10 * CLK_PERIOD;    // Worst case per operation
	localparam cdb_t NO_CDB       = '0;                 // Idle broadcast

	logic                clock;
	logic                reset;
	logic                dispatch_valid;
	dispatch_t           dispatch;
	cdb_t                cdb1;
	cdb_t                cdb2;
	logic [NUM_FU-1:0]   fu_available;
	logic                dispatch_ready;
	issue_t              issue_alu;
	issue_t              issue_mult;
	issue_t              issue_mem;

	int                  errors;
	int                  checks;

	reservation_station UUT
	(
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.cdb1           (cdb1),
		.cdb2           (cdb2),
		.fu_available   (fu_available),
		.dispatch_ready (dispatch_ready),
		.issue_alu      (issue_alu),
		.issue_mult     (issue_mult),
		.issue_mem      (issue_mem)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;            // 4 ns period

	////////////////////////////////////////
	// Stimulus builders
	////////////////////////////////////////

	// Ready instruction with random operands and an op fitting the unit
	function automatic dispatch_t ready_instr(fu_sel_e u);
		dispatch_t d;
		logic      alt;
		alt = $urandom_range(0, 1);
		d = '0;
		d.opa.valid = 1'b1;
		d.opa.data  = {$urandom, $urandom};
		d.opb.valid = 1'b1;
		d.opb.data  = {$urandom, $urandom};
		d.dest_tag  = $urandom_range(0, PRN_SIZE - 1);
		d.rob_idx   = $urandom_range(0, ROB_SIZE - 1);
		d.fu        = u;
		case (u)
			FU_ALU:  d.op = alt ? OP_SUB  : OP_ADD;
			FU_MULT: d.op = alt ? OP_MULH : OP_MUL;
			default: d.op = alt ? OP_ST   : OP_LD;
		endcase
		return d;
	endfunction

	// Packet a unit should see for a ready dispatch
	function automatic issue_t expected_issue(dispatch_t d);
		issue_t e;
		e = '0;
		e.valid    = 1'b1;
		e.opa      = d.opa.data;
		e.opb      = d.opb.data;
		e.dest_tag = d.dest_tag;
		e.rob_idx  = d.rob_idx;
		e.op       = d.op;
		return e;
	endfunction

	function automatic cdb_t result_bus(logic [TAG_W-1:0] tag, logic [XLEN-1:0] data);
		cdb_t c;
		c.valid = 1'b1;
		c.tag   = tag;
		c.data  = data;
		return c;
	endfunction

	function automatic issue_t unit_output(fu_sel_e u);
		case (u)
			FU_ALU:  return issue_alu;
			FU_MULT: return issue_mult;
			default: return issue_mem;
		endcase
	endfunction

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic compare_issue(input issue_t got, input issue_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic verify_ready(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s, dispatch_ready %b expected %b", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////

	// Offer one instruction with optional broadcasts alongside in the first cycle
	task automatic dispatch_one(input dispatch_t d, input cdb_t c1, input cdb_t c2);
		int waited;
		waited = 0;
		@(posedge clock);
		dispatch_valid <= 1'b1;
		dispatch       <= d;
		cdb1           <= c1;
		cdb2           <= c2;
		@(negedge clock);
		while (!dispatch_ready && waited < READY_WAIT)
		begin
			@(negedge clock);
			waited++;
		end
		if (!dispatch_ready)
		begin
			errors++;
			$display("Dispatch was not accepted within %0d cycles, station stayed full", waited);
		end
		@(posedge clock);                           // Transfer edge
		dispatch_valid <= 1'b0;
		cdb1           <= '0;
		cdb2           <= '0;
	endtask

	task automatic broadcast(input cdb_t c1, input cdb_t c2);
		@(posedge clock);
		cdb1 <= c1;
		cdb2 <= c2;
		@(posedge clock);                           // Captured here
		cdb1 <= '0;
		cdb2 <= '0;
	endtask

	// Wait for a packet on one unit for at most max_cycles sample points
	task automatic expect_issue(input fu_sel_e u, input issue_t exp, input int max_cycles);
		issue_t got;
		got = '0;
		for (int n = 0; n < max_cycles; n++)
		begin
			@(negedge clock);
			got = unit_output(u);
			if (got.valid)
				break;
		end
		if (!got.valid)
		begin
			errors++;
			$display("Unit %s issued nothing within %0d cycles", u.name(), max_cycles);
		end
		else
			compare_issue(got, exp, {u.name(), " issue"});
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic immediate_issue();
		dispatch_t d;
		for (int u = 0; u < NUM_FU; u++)
		begin
			d = ready_instr(fu_sel_e'(u));
			dispatch_one(d, NO_CDB, NO_CDB);
			expect_issue(fu_sel_e'(u), expected_issue(d), 1);   // Next cycle exactly
		end
	endtask

	task automatic operand_wakeup();
		dispatch_t   d;
		issue_t      exp;
		logic [63:0] val_a;
		logic [63:0] val_b;
		val_a = {$urandom, $urandom};
		val_b = {$urandom, $urandom};
		d = ready_instr(FU_ALU);
		d.opa = '{valid: 1'b0, data: 64'h25};               // Tag 0x25 pending
		d.opb = '{valid: 1'b0, data: 64'h3a};               // Tag 0x3a pending
		exp = expected_issue(d);
		exp.opa = val_a;
		exp.opb = val_b;
		dispatch_one(d, NO_CDB, NO_CDB);
		@(negedge clock);
		compare_issue(issue_alu, '0, "pending operands issued");
		// Low five bits match both pending tags
		broadcast(result_bus(6'h05, 64'hdead), result_bus(6'h1a, 64'hbeef));
		@(negedge clock);
		compare_issue(issue_alu, '0, "woken by partial tag");
		broadcast(result_bus(6'h25, val_a), NO_CDB);
		@(negedge clock);
		compare_issue(issue_alu, '0, "issued with opb pending");
		broadcast(NO_CDB, result_bus(6'h3a, val_b));
		expect_issue(FU_ALU, exp, 1);
		// Both buses hit the operands on the dispatch cycle itself
		d = ready_instr(FU_MEM);
		d.opa = '{valid: 1'b0, data: 64'h11};
		d.opb = '{valid: 1'b0, data: 64'h12};
		exp = expected_issue(d);
		exp.opa = val_b;
		exp.opb = val_a;
		dispatch_one(d, result_bus(6'h11, val_b), result_bus(6'h12, val_a));
		expect_issue(FU_MEM, exp, 1);
	endtask

	task automatic unit_backpressure();
		dispatch_t d_mul;
		dispatch_t d_alu;
		dispatch_t d_mem;
		@(posedge clock);
		fu_available <= 3'b101;                             // Multiplier off
		d_mul = ready_instr(FU_MULT);
		dispatch_one(d_mul, NO_CDB, NO_CDB);
		d_alu = ready_instr(FU_ALU);
		dispatch_one(d_alu, NO_CDB, NO_CDB);
		expect_issue(FU_ALU, expected_issue(d_alu), 1);
		compare_issue(issue_mult, '0, "multiply issued while unavailable");
		d_mem = ready_instr(FU_MEM);
		dispatch_one(d_mem, NO_CDB, NO_CDB);
		expect_issue(FU_MEM, expected_issue(d_mem), 1);
		compare_issue(issue_mult, '0, "multiply issued while unavailable");
		@(posedge clock);
		fu_available <= 3'b111;
		expect_issue(FU_MULT, expected_issue(d_mul), 1);
		// Three ready together and released in one cycle
		@(posedge clock);
		fu_available <= 3'b000;
		d_alu = ready_instr(FU_ALU);
		d_mul = ready_instr(FU_MULT);
		d_mem = ready_instr(FU_MEM);
		dispatch_one(d_alu, NO_CDB, NO_CDB);
		dispatch_one(d_mul, NO_CDB, NO_CDB);
		dispatch_one(d_mem, NO_CDB, NO_CDB);
		@(posedge clock);
		fu_available <= 3'b111;
		expect_issue(FU_ALU, expected_issue(d_alu), 1);
		compare_issue(issue_mult, expected_issue(d_mul), "parallel multiply");
		compare_issue(issue_mem, expected_issue(d_mem), "parallel memory");
	endtask

	task automatic full_station();
		dispatch_t d [NUM_ENTRIES];
		@(posedge clock);
		fu_available <= 3'b110;                             // ALU off
		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			d[i] = ready_instr(FU_ALU);
			dispatch_one(d[i], NO_CDB, NO_CDB);
		end
		@(negedge clock);
		verify_ready(dispatch_ready, 1'b0, "station full");
		@(posedge clock);
		fu_available <= 3'b111;
		for (int i = 0; i < NUM_ENTRIES; i++)
			expect_issue(FU_ALU, expected_issue(d[i]), 1);  // One per cycle in entry order
		@(negedge clock);
		verify_ready(dispatch_ready, 1'b1, "station drained");
	endtask

	// Scoreboard mirrors the entries and the lowest busy entry per unit issues
	task automatic random_traffic();
		issue_t    model_pkt [NUM_ENTRIES];
		fu_sel_e   model_fu [NUM_ENTRIES];
		bit        model_busy [NUM_ENTRIES];
		dispatch_t d;
		issue_t    exp;
		bit        offer;
		int        slot;
		for (int i = 0; i < NUM_ENTRIES; i++)
			model_busy[i] = 1'b0;
		for (int c = 0; c < RANDOM_CYCLES + 2; c++)
		begin
			offer = (c < RANDOM_CYCLES) && ($urandom_range(0, 3) != 0);
			d = ready_instr(fu_sel_e'($urandom_range(0, NUM_FU - 1)));
			@(posedge clock);
			dispatch_valid <= offer;
			dispatch       <= d;
			@(negedge clock);
			slot = -1;
			for (int i = NUM_ENTRIES - 1; i >= 0; i--)
				if (!model_busy[i])
					slot = i;                               // Lowest free
			verify_ready(dispatch_ready, slot >= 0, "random traffic");
			for (int u = 0; u < NUM_FU; u++)
			begin
				exp = '0;
				for (int i = 0; i < NUM_ENTRIES; i++)
				begin
					if (model_busy[i] && model_fu[i] == fu_sel_e'(u) && !exp.valid)
					begin
						exp           = model_pkt[i];
						model_busy[i] = 1'b0;                // Freed at next edge
					end
				end
				compare_issue(unit_output(fu_sel_e'(u)), exp, $sformatf("random unit %0d", u));
			end
			if (offer && slot >= 0)
			begin
				model_busy[slot] = 1'b1;
				model_pkt[slot]  = expected_issue(d);
				model_fu[slot]   = d.fu;
			end
		end
		@(posedge clock);
		dispatch_valid <= 1'b0;
	endtask

	////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////

	initial
	begin
		clock          = 1'b0;
		reset          = 1'b1;
		dispatch_valid = 1'b0;
		dispatch       = '0;
		cdb1           = '0;
		cdb2           = '0;
		fu_available   = '1;
		errors         = 0;
		checks         = 0;
		void'($urandom(SEED));
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		verify_ready(dispatch_ready, 1'b1, "after reset");
		compare_issue(issue_alu, '0, "ALU after reset");
		compare_issue(issue_mult, '0, "multiplier after reset");
		compare_issue(issue_mem, '0, "memory after reset");
		immediate_issue();
		operand_wakeup();
		unit_backpressure();
		full_station();
		random_traffic();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		#(TEST_OPS * OP_BOUND_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
